// ==== boot_console.f ====
+incdir+design
design/boot_pkg.sv
design/uart_rx.sv
design/word_assembler.sv
design/program_loader.sv
design/console_tx_buffer.sv
design/uart_tx.sv
design/boot_console.sv
testbench/tb_boot_console.sv

// ==== Bender.yml ====
package:
  name: boot_console

sources:
  - include_dirs:
      - design
    files:
      - design/boot_pkg.sv
      - design/uart_rx.sv
      - design/word_assembler.sv
      - design/program_loader.sv
      - design/console_tx_buffer.sv
      - design/uart_tx.sv
      - design/boot_console.sv
  - target: test
    files:
      - testbench/tb_boot_console.sv

// ==== testbench/tb_boot_console.sv ====
module tb_boot_console;

  localparam int BIT_CLKS   = 8;
  localparam int FRAME_CLKS = 10 * BIT_CLKS;
  localparam int CLK_PERIOD = 100;
  // frames for the image, the trailing word and all console bytes
  localparam int SERIAL_FRAMES = 40 + 4 + 3 + 4 + 64;
  localparam int WATCHDOG_TIME = 2 * SERIAL_FRAMES * FRAME_CLKS * CLK_PERIOD;

  logic             clk;
  logic             rstn;
  logic             rxd;
  logic             txd;
  logic             dmem_we;
  boot_pkg::addr_t  dmem_addr;
  boot_pkg::word_t  dmem_wdata;
  logic             imem_we;
  boot_pkg::addr_t  imem_addr;
  boot_pkg::word_t  imem_wdata;
  boot_pkg::addr_t  first_pc;
  boot_pkg::count_t program_words;
  logic             load_done;
  logic             out_we;
  boot_pkg::word_t  out_data;
  logic             out_is_word;
  logic             out_full;

  int              errors;
  int              checks;
  int              seed;
  boot_pkg::word_t image[$];
  boot_pkg::word_t dmem_exp[$];
  boot_pkg::word_t imem_exp[$];
  boot_pkg::byte_t tx_exp[$];
  boot_pkg::byte_t tx_seen[$];
  boot_pkg::addr_t dmem_next;
  boot_pkg::addr_t imem_next;
  boot_pkg::addr_t pc_sent;

  boot_console #(.CLKS_PER_BIT(BIT_CLKS)) i_boot_console (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // bounded by twice the serial time of all traffic
  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired, the run did not reach its end");
    $display("Verification failed");
    $finish;
  end

  // loader strobes are single-cycle and never together
  we_exclusive: assert property (@(posedge clk) disable iff (!rstn) !(dmem_we && imem_we))
    else begin
      errors++;
      $display("dmem_we and imem_we high together at %0t", $time);
    end
  dmem_single_pulse: assert property (@(posedge clk) disable iff (!rstn) dmem_we |=> !dmem_we)
    else begin
      errors++;
      $display("dmem_we held longer than one cycle at %0t", $time);
    end
  imem_single_pulse: assert property (@(posedge clk) disable iff (!rstn) imem_we |=> !imem_we)
    else begin
      errors++;
      $display("imem_we held longer than one cycle at %0t", $time);
    end
  // program_words is zero until the header is through
  no_header_write: assert property (@(posedge clk) disable iff (!rstn)
    (dmem_we || imem_we) |-> program_words == 32'd4)
    else begin
      errors++;
      $display("memory write before header decoded at %0t", $time);
    end
  done_after_last: assert property (@(posedge clk) disable iff (!rstn)
    $rose(load_done) |-> $past(imem_we) && $past(imem_addr) == 32'd12)
    else begin
      errors++;
      $display("load_done rose without the last imem write at %0t", $time);
    end
  done_sticky: assert property (@(posedge clk) disable iff (!rstn) load_done |=> load_done)
    else begin
      errors++;
      $display("load_done dropped at %0t", $time);
    end
  quiet_after_done: assert property (@(posedge clk) disable iff (!rstn)
    load_done |-> !(dmem_we || imem_we))
    else begin
      errors++;
      $display("memory write after load_done at %0t", $time);
    end

  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
  endtask

  // 8N1 frame on rxd with lsb first
  task automatic transmit_byte(input boot_pkg::byte_t b);
    int i;
    rxd = 1'b0;
    repeat (BIT_CLKS) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      rxd = b[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
    rxd = 1'b1;
    repeat (BIT_CLKS) @(negedge clk);
  endtask

  // image words go out msb first
  task automatic send_word(input boot_pkg::word_t w);
    int i;
    for (i = 3; i >= 0; i--) begin
      transmit_byte(w[i*8 +: 8]);
    end
  endtask

  task automatic request_output(input boot_pkg::word_t data, input logic is_word);
    out_we      = 1'b1;
    out_data    = data;
    out_is_word = is_word;
    @(negedge clk);
    out_we = 1'b0;
  endtask

  task automatic check_header();
    int n;
    n = 0;
    while (program_words == '0 && n < 16 * FRAME_CLKS) begin
      @(negedge clk);
      n++;
    end
    check_value("program_words", program_words, 32'd4);
    check_value("first_pc", first_pc, pc_sent);
  endtask

  // wait for the queued bytes and a quiet gap for extras
  task automatic expect_console();
    int n;
    n = 0;
    while (tx_seen.size() < tx_exp.size() && n < 2 * FRAME_CLKS * tx_exp.size() + 100) begin
      @(negedge clk);
      n++;
    end
    repeat (2 * FRAME_CLKS) @(negedge clk);
    check_value("txd byte count", tx_seen.size(), tx_exp.size());
    while (tx_seen.size() > 0 && tx_exp.size() > 0) begin
      check_value("txd byte", tx_seen.pop_front(), tx_exp.pop_front());
    end
    tx_seen.delete();
    tx_exp.delete();
  endtask

  // loader writes against the queued image
  always @(negedge clk) begin
    if (rstn && dmem_we) begin
      check_value("dmem words pending", dmem_exp.size() > 0, 1'b1);
      if (dmem_exp.size() > 0) begin
        check_value("dmem_wdata", dmem_wdata, dmem_exp.pop_front());
        check_value("dmem_addr", dmem_addr, dmem_next);
        dmem_next += 4;
      end
    end
    if (rstn && imem_we) begin
      check_value("imem words pending", imem_exp.size() > 0, 1'b1);
      if (imem_exp.size() > 0) begin
        check_value("imem_wdata", imem_wdata, imem_exp.pop_front());
        check_value("imem_addr", imem_addr, imem_next);
        imem_next += 4;
      end
    end
  end

  // txd decoder sampling mid-bit on the falling clock edge
  initial begin
    boot_pkg::byte_t b;
    int i;
    wait (rstn === 1'b1);
    forever begin
      @(negedge txd);
      repeat (BIT_CLKS / 2) @(negedge clk);
      assert (txd == 1'b0)
        else begin
          errors++;
          $display("start bit on txd too short at %0t", $time);
        end
      for (i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        b[i] = txd;
      end
      repeat (BIT_CLKS) @(negedge clk);
      assert (txd == 1'b1)
        else begin
          errors++;
          $display("missing stop bit on txd at %0t", $time);
        end
      tx_seen.push_back(b);
    end
  end

  initial begin
    int i;
    int n;
    boot_pkg::word_t w;
    rstn        = 1'b0;
    rxd         = 1'b1;
    out_we      = 1'b0;
    out_data    = '0;
    out_is_word = 1'b0;
    errors      = 0;
    checks      = 0;
    seed        = 32'h3486c2c8;
    dmem_next   = '0;
    imem_next   = '0;
    // two rising edges in reset, release on the falling edge
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    // 40-byte image with 3 data words then 4 program words
    pc_sent = $random(seed) & 32'hffff_fffc;
    image.push_back(32'd40);
    image.push_back(32'd3);
    image.push_back(pc_sent);
    for (i = 0; i < 7; i++) begin
      w = $random(seed);
      image.push_back(w);
      if (i < 3) begin
        dmem_exp.push_back(w);
      end else begin
        imem_exp.push_back(w);
      end
    end
    fork
      foreach (image[k]) send_word(image[k]);
      check_header();
    join
    n = 0;
    while (!load_done && n < FRAME_CLKS) begin
      @(negedge clk);
      n++;
    end
    check_value("load_done", load_done, 1'b1);
    check_value("dmem words left", dmem_exp.size(), 0);
    check_value("imem words left", imem_exp.size(), 0);
    // trailing word must be ignored
    send_word($random(seed));
    repeat (FRAME_CLKS) @(negedge clk);
    check_value("load_done", load_done, 1'b1);

    // three byte requests where upper bits are ignored
    for (i = 0; i < 3; i++) begin
      w = $random(seed);
      tx_exp.push_back(w[7:0]);
      request_output(w, 1'b0);
    end
    expect_console();

    // one word request goes out low byte first
    w = $random(seed);
    tx_exp.push_back(w[7:0]);
    tx_exp.push_back(w[15:8]);
    tx_exp.push_back(w[23:16]);
    tx_exp.push_back(w[31:24]);
    request_output(w, 1'b1);
    expect_console();

    // the 65th back-to-back request finds the buffer full
    for (i = 0; i < 65; i++) begin
      w = $random(seed);
      check_value("out_full", out_full, i == 64);
      if (i < 64) begin
        tx_exp.push_back(w[7:0]);
      end
      request_output(w, 1'b0);
    end
    n = 0;
    while (out_full && n < 4 * FRAME_CLKS) begin
      @(negedge clk);
      n++;
    end
    check_value("out_full", out_full, 1'b0);
    check_value("txd bytes when out_full fell", tx_seen.size(), 1);
    expect_console();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== design/boot_console.sv ====
`include "boot_defines.svh"

module boot_console #(
  parameter int CLKS_PER_BIT = `BOOT_CLKS_PER_BIT
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             rxd,
  output logic             txd,
  output logic             dmem_we,
  output boot_pkg::addr_t  dmem_addr,
  output boot_pkg::word_t  dmem_wdata,
  output logic             imem_we,
  output boot_pkg::addr_t  imem_addr,
  output boot_pkg::word_t  imem_wdata,
  output boot_pkg::addr_t  first_pc,
  output boot_pkg::count_t program_words,
  output logic             load_done,
  input  logic             out_we,
  input  boot_pkg::word_t  out_data,
  input  logic             out_is_word,
  output logic             out_full
);

  boot_pkg::byte_t rx_byte;
  logic            rx_strobe;
  boot_pkg::word_t word;
  logic            word_valid;
  boot_pkg::byte_t tx_byte;
  logic            tx_start;
  logic            tx_busy;

  // receive path, serial to words
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
    .clk, .rstn, .rxd, .rx_byte, .rx_strobe
  );

  word_assembler i_word_assembler (
    .clk, .rstn, .rx_byte, .rx_strobe, .word, .word_valid
  );

  // header decode and memory writes
  program_loader i_program_loader (
    .clk, .rstn, .word, .word_valid,
    .dmem_we, .dmem_addr, .dmem_wdata,
    .imem_we, .imem_addr, .imem_wdata,
    .first_pc, .program_words, .load_done
  );

  // console output, words split low byte first
  console_tx_buffer i_console_tx_buffer (
    .clk, .rstn, .out_we, .out_data, .out_is_word, .out_full,
    .tx_byte, .tx_start, .tx_busy
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
    .clk, .rstn, .tx_byte, .tx_start, .tx_busy, .txd
  );

endmodule

// ==== design/uart_tx.sv ====
`include "boot_defines.svh"

module uart_tx #(
  parameter int CLKS_PER_BIT = `BOOT_CLKS_PER_BIT
) (
  input  logic            clk,
  input  logic            rstn,
  input  boot_pkg::byte_t tx_byte,
  input  logic            tx_start,
  output logic            tx_busy,
  output logic            txd
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  boot_pkg::uart_state_e state;
  logic [CNT_W-1:0]      cnt;
  logic [2:0]            bit_idx;
  boot_pkg::byte_t       shreg;
  logic                  bit_end;

  assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1));
  // busy from the cycle after tx_start until stop bit ends
  assign tx_busy = (state != boot_pkg::st_idle);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= boot_pkg::st_idle;
      cnt     <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        boot_pkg::st_idle: begin
          cnt <= '0;
          txd <= 1'b1;
          if (tx_start) begin
            txd   <= 1'b0;
            state <= boot_pkg::st_start;
          end
        end
        boot_pkg::st_start: begin
          if (bit_end) begin
            txd     <= shreg[0];
            bit_idx <= '0;
            state   <= boot_pkg::st_bits;
          end
        end
        boot_pkg::st_bits: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            txd     <= shreg[bit_idx + 1'b1];
            if (bit_idx == 3'd7) begin
              txd   <= 1'b1;
              state <= boot_pkg::st_stop;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= boot_pkg::st_idle;
          end
        end
      endcase
    end
  end

  // byte held for the whole frame
  always_ff @(posedge clk) begin
    if (state == boot_pkg::st_idle && tx_start) begin
      shreg <= tx_byte;
    end
  end

endmodule

// ==== design/console_tx_buffer.sv ====
`include "boot_defines.svh"

module console_tx_buffer (
  input  logic            clk,
  input  logic            rstn,
  input  logic            out_we,
  input  boot_pkg::word_t out_data,
  input  logic            out_is_word,
  output logic            out_full,
  output boot_pkg::byte_t tx_byte,
  output logic            tx_start,
  input  logic            tx_busy
);

  localparam int AW    = `BOOT_TXBUF_AW;
  localparam int DEPTH = 1 << AW;

  // entry = {word flag, data}
  logic [`BOOT_WORD_W:0] mem [DEPTH];
  logic [AW:0]           wr_ptr;
  logic [AW:0]           rd_ptr;
  logic                  empty;
  logic                  head_is_word;
  boot_pkg::word_t       head_data;
  boot_pkg::lane_t       lane;
  logic                  last_sent;
  logic                  can_start;
  logic                  last_lane;

  // extra pointer bit tells full from empty
  assign empty    = (wr_ptr == rd_ptr);
  assign out_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign {head_is_word, head_data} = mem[rd_ptr[AW-1:0]];

  // start only when uart is idle and no start in flight
  assign can_start = !empty && !tx_busy && !tx_start && !last_sent;
  // byte entry has a single lane
  assign last_lane = !head_is_word || (lane == 2'd3);

  // requests while full are dropped
  always_ff @(posedge clk) begin
    if (out_we && !out_full) begin
      mem[wr_ptr[AW-1:0]] <= {out_is_word, out_data};
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      lane      <= '0;
      last_sent <= 1'b0;
      tx_start  <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      if (out_we && !out_full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (can_start) begin
        tx_start <= 1'b1;
        if (last_lane) begin
          lane      <= '0;
          last_sent <= 1'b1;
        end else begin
          lane <= lane + 1'b1;
        end
      end
      // entry stays pending until its last byte is out
      if (last_sent && !tx_busy && !tx_start) begin
        last_sent <= 1'b0;
        rd_ptr    <= rd_ptr + 1'b1;
      end
    end
  end

  // low byte first
  always_ff @(posedge clk) begin
    if (can_start) begin
      tx_byte <= head_data[lane*8 +: 8];
    end
  end

endmodule

// ==== design/program_loader.sv ====
`include "boot_defines.svh"

module program_loader (
  input  logic             clk,
  input  logic             rstn,
  input  boot_pkg::word_t  word,
  input  logic             word_valid,
  output logic             dmem_we,
  output boot_pkg::addr_t  dmem_addr,
  output boot_pkg::word_t  dmem_wdata,
  output logic             imem_we,
  output boot_pkg::addr_t  imem_addr,
  output boot_pkg::word_t  imem_wdata,
  output boot_pkg::addr_t  first_pc,
  output boot_pkg::count_t program_words,
  output logic             load_done
);

  boot_pkg::loader_state_e state;
  boot_pkg::count_t        total_bytes;
  boot_pkg::count_t        data_left;
  boot_pkg::count_t        prog_left;
  boot_pkg::count_t        prog_count;

  // program words = total/4 - header - data words
  assign prog_count = (total_bytes >> 2) - boot_pkg::count_t'(`BOOT_HEADER_WORDS) - data_left;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state         <= boot_pkg::st_size;
      total_bytes   <= '0;
      data_left     <= '0;
      prog_left     <= '0;
      first_pc      <= '0;
      program_words <= '0;
      dmem_we       <= 1'b0;
      imem_we       <= 1'b0;
      dmem_addr     <= '0;
      imem_addr     <= '0;
      load_done     <= 1'b0;
    end else begin
      dmem_we <= 1'b0;
      imem_we <= 1'b0;
      // step address once the write pulse is over
      if (dmem_we) begin
        dmem_addr <= dmem_addr + 32'd4;
      end
      if (imem_we) begin
        imem_addr <= imem_addr + 32'd4;
      end
      case (state)
        boot_pkg::st_size: begin
          if (word_valid) begin
            total_bytes <= word;
            state       <= boot_pkg::st_data_count;
          end
        end
        boot_pkg::st_data_count: begin
          if (word_valid) begin
            data_left <= word;
            state     <= boot_pkg::st_pc;
          end
        end
        boot_pkg::st_pc: begin
          if (word_valid) begin
            first_pc      <= word;
            program_words <= prog_count;
            prog_left     <= prog_count;
            // empty image finishes right here
            if (data_left == '0 && prog_count == '0) begin
              load_done <= 1'b1;
              state     <= boot_pkg::st_done;
            end else if (data_left == '0) begin
              state <= boot_pkg::st_program;
            end else begin
              state <= boot_pkg::st_data;
            end
          end
        end
        boot_pkg::st_data: begin
          if (word_valid) begin
            dmem_we   <= 1'b1;
            data_left <= data_left - 1'b1;
            // last data word, skip program if empty
            if (data_left == 32'd1) begin
              state <= (prog_left == '0) ? boot_pkg::st_done : boot_pkg::st_program;
            end
          end
        end
        boot_pkg::st_program: begin
          if (word_valid) begin
            imem_we   <= 1'b1;
            prog_left <= prog_left - 1'b1;
            if (prog_left == 32'd1) begin
              state <= boot_pkg::st_done;
            end
          end
        end
        default: begin
          // trailing words are ignored
          load_done <= 1'b1;
        end
      endcase
    end
  end

  // write data follows the strobe
  always_ff @(posedge clk) begin
    if (word_valid && state == boot_pkg::st_data) begin
      dmem_wdata <= word;
    end
    if (word_valid && state == boot_pkg::st_program) begin
      imem_wdata <= word;
    end
  end

endmodule

// ==== design/word_assembler.sv ====
`include "boot_defines.svh"

module word_assembler (
  input  logic            clk,
  input  logic            rstn,
  input  boot_pkg::byte_t rx_byte,
  input  logic            rx_strobe,
  output boot_pkg::word_t word,
  output logic            word_valid
);

  boot_pkg::lane_t lane;
  boot_pkg::word_t word_q;

  // lane counter and completion pulse
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lane       <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (rx_strobe) begin
        lane <= lane + 1'b1;
        // fourth byte completes the word
        if (lane == 2'd3) begin
          word_valid <= 1'b1;
        end
      end
    end
  end

  // shift from the low end
  // first byte ends up in bits 31:24
  always_ff @(posedge clk) begin
    if (rx_strobe) begin
      word_q <= {word_q[`BOOT_WORD_W-9:0], rx_byte};
    end
  end

  // stable while word_valid is high
  assign word = word_q;

endmodule

// ==== design/uart_rx.sv ====
`include "boot_defines.svh"

module uart_rx #(
  parameter int CLKS_PER_BIT = `BOOT_CLKS_PER_BIT
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             rxd,
  output boot_pkg::byte_t  rx_byte,
  output logic             rx_strobe
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  logic                  rxd_meta;
  logic                  rxd_sync;
  boot_pkg::uart_state_e state;
  logic [CNT_W-1:0]      cnt;
  logic [2:0]            bit_idx;
  boot_pkg::byte_t       shreg;

  // two-flop synchroniser, idles high like the line
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= boot_pkg::st_idle;
      cnt       <= '0;
      bit_idx   <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      cnt       <= cnt + 1'b1;
      case (state)
        boot_pkg::st_idle: begin
          cnt <= '0;
          // falling edge of start bit
          if (!rxd_sync) begin
            state <= boot_pkg::st_start;
          end
        end
        boot_pkg::st_start: begin
          // half a bit in, recheck for a glitch
          if (cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rxd_sync ? boot_pkg::st_idle : boot_pkg::st_bits;
          end
        end
        boot_pkg::st_bits: begin
          // mid-bit of each data bit
          if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= boot_pkg::st_stop;
            end
          end
        end
        default: begin
          // mid stop bit, good frame only when high
          if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt       <= '0;
            rx_strobe <= rxd_sync;
            state     <= boot_pkg::st_idle;
          end
        end
      endcase
    end
  end

  // lsb first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == boot_pkg::st_bits && cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
      shreg <= {rxd_sync, shreg[7:1]};
    end
  end

  assign rx_byte = shreg;

endmodule

// ==== design/boot_pkg.sv ====
`include "boot_defines.svh"

package boot_pkg;

  // memory or console word
  typedef logic [`BOOT_WORD_W-1:0] word_t;
  // one serial byte
  typedef logic [7:0] byte_t;
  // byte address into dmem or imem
  typedef logic [31:0] addr_t;
  // word count
  typedef logic [31:0] count_t;
  // byte index within a word
  typedef logic [1:0] lane_t;

  // loader phases, header words first, then payload sections
  typedef enum logic [2:0] {
    st_size,
    st_data_count,
    st_pc,
    st_data,
    st_program,
    st_done
  } loader_state_e;

  // serial frame phases, shared by rx and tx
  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_bits,
    st_stop
  } uart_state_e;

endpackage

// ==== design/boot_defines.svh ====
`ifndef BOOT_DEFINES_SVH
`define BOOT_DEFINES_SVH

// data word width, shared by memories and console
`define BOOT_WORD_W 32

// clock cycles per serial bit
// 100 MHz clock at 115200 baud
`define BOOT_CLKS_PER_BIT 868

// console buffer address bits
// 6 bits give 64 pending entries
`define BOOT_TXBUF_AW 6

// image header length in words
// total bytes, data word count, first pc
`define BOOT_HEADER_WORDS 3

`endif
